// File: filelist.f
+incdir+hdl
hdl/mips_pkg.sv
hdl/ex_ctrl_if.sv
hdl/ex_mem_if.sv
hdl/pipeline_control.sv
hdl/fetch_unit.sv
hdl/register_file.sv
hdl/execute_unit.sv
hdl/memory_unit.sv
hdl/mips_core.sv
verif/mips_core_tb.sv

// File: verif/mips_core_tb.sv
////////////////////////////////////////
// programs avoid lw use in the next slot
// run drops before the register readout
////////////////////////////////////////
`timescale 1ns/1ns
`include "mips_defs.svh"

module mips_core_tb;

    localparam int NCASES   = 5;
    localparam int MAX_WAIT = 100;  // edge limit for one wait

    logic        SYS_clk;
    logic        SYS_reset;
    logic        run;
    logic        imem_we;
    logic [5:0]  imem_addr;
    logic [31:0] imem_data;
    logic [4:0]  reg_addr;
    logic [31:0] reg_data;

    string       case_name [NCASES];
    int          case_len  [NCASES];
    logic [31:0] prog      [NCASES][16];
    logic [31:0] exp_regs  [32];
    logic [31:0] model_mem [`MIPS_DMEM_WORDS];
    logic [31:0] rng_state;
    int          checks;
    int          errors;
    int          timeouts;

    mips_core mips_core_i
    (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .run       (run),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .reg_addr  (reg_addr),
        .reg_data  (reg_data)
    );

    always #5 SYS_clk = ~SYS_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
        return {`MIPS_OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task add_word(input int c, input logic [31:0] w);
        prog[c][case_len[c]] = w;
        case_len[c]++;
    endtask

    task build_cases;
        int          i;
        logic [15:0] imm;
        for (i = 0; i < NCASES; i++)
            case_len[i] = 0;
        case_name[0] = "alu_independent";
        add_word(0, enc_i(`MIPS_OP_ADDI, 0, 1, -16'sd7));
        add_word(0, enc_i(`MIPS_OP_ADDI, 0, 2, 16'd12));
        add_word(0, 32'h0);
        add_word(0, 32'h0);
        add_word(0, 32'h0);
        add_word(0, enc_r(1, 2, 3, `MIPS_FN_ADD));
        add_word(0, enc_r(1, 2, 4, `MIPS_FN_SUB));
        add_word(0, enc_r(1, 2, 5, `MIPS_FN_AND));
        add_word(0, enc_r(1, 2, 6, `MIPS_FN_OR));
        add_word(0, enc_r(1, 2, 7, `MIPS_FN_SLT)); // negative vs positive
        add_word(0, enc_r(2, 1, 8, `MIPS_FN_SLT));
        case_name[1] = "addi_random";
        for (i = 1; i <= 10; i++)
        begin
            rng_state = xorshift32(rng_state);
            imm = rng_state[15:0];
            if (i % 2 == 0)
                imm[15] = 1'b1; // force a negative immediate
            add_word(1, enc_i(`MIPS_OP_ADDI, (i > 8) ? 5'(i - 8) : 5'd0, 5'(i), imm));
        end
        case_name[2] = "fwd_ex_mem";
        add_word(2, enc_i(`MIPS_OP_ADDI, 0, 1, 16'd10));
        add_word(2, enc_r(1, 0, 2, `MIPS_FN_ADD));  // rs from EX/MEM
        add_word(2, enc_r(0, 2, 3, `MIPS_FN_SUB));  // rt from EX/MEM
        add_word(2, enc_r(3, 3, 4, `MIPS_FN_ADD));  // both
        add_word(2, enc_r(4, 1, 5, `MIPS_FN_OR));
        add_word(2, enc_r(5, 4, 6, `MIPS_FN_SLT));
        add_word(2, enc_i(`MIPS_OP_ADDI, 0, 7, 16'd1));
        add_word(2, enc_i(`MIPS_OP_ADDI, 0, 7, 16'd2));
        add_word(2, enc_r(7, 0, 8, `MIPS_FN_ADD));  // newer of two in-flight producers
        case_name[3] = "fwd_mem_wb";
        add_word(3, enc_i(`MIPS_OP_ADDI, 0, 1, 16'd7));
        add_word(3, 32'h0);
        add_word(3, enc_r(1, 1, 2, `MIPS_FN_ADD));  // distance two
        add_word(3, enc_i(`MIPS_OP_ADDI, 0, 3, -16'sd4));
        add_word(3, 32'h0);
        add_word(3, 32'h0);
        add_word(3, enc_r(3, 1, 4, `MIPS_FN_SUB));  // distance three
        add_word(3, enc_i(`MIPS_OP_ADDI, 0, 5, 16'd3));
        add_word(3, enc_i(`MIPS_OP_ADDI, 0, 6, 16'd9));
        add_word(3, enc_r(5, 6, 7, `MIPS_FN_AND));  // rs two back, rt one back
        case_name[4] = "mem_and_misc";
        add_word(4, enc_i(`MIPS_OP_ADDI, 0, 1, 16'd100));
        add_word(4, enc_i(`MIPS_OP_ADDI, 0, 2, 16'h0055));
        add_word(4, enc_i(`MIPS_OP_SW, 0, 2, 16'd8));
        add_word(4, enc_i(`MIPS_OP_ADDI, 0, 3, -16'sd1));
        add_word(4, enc_i(`MIPS_OP_SW, 0, 3, 16'd12)); // store data forwarded
        add_word(4, enc_i(`MIPS_OP_SW, 0, 1, 16'd20));
        add_word(4, enc_i(`MIPS_OP_ADDI, 0, 0, 16'd5));
        add_word(4, enc_r(3, 3, 0, `MIPS_FN_ADD));
        add_word(4, enc_r(1, 2, 7, 6'h3f));            // unsupported funct
        add_word(4, enc_i(`MIPS_OP_LW, 0, 4, 16'd8));
        add_word(4, enc_i(`MIPS_OP_LW, 0, 5, 16'd12));
        add_word(4, enc_i(`MIPS_OP_LW, 0, 8, 16'd20));
        add_word(4, 32'h0);
        add_word(4, enc_r(4, 5, 6, `MIPS_FN_ADD));
        add_word(4, enc_i(`MIPS_OP_ADDI, 8, 9, 16'd1));
    endtask

    // sequential ISA model, one instruction at a time
    task model_case(input int c);
        int          pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] val;
        logic [4:0]  dst;
        logic        wr;
        for (pc = 0; pc < 32; pc++)
            exp_regs[pc] = '0;
        for (pc = 0; pc < `MIPS_DMEM_WORDS; pc++)
            model_mem[pc] = '0;
        for (pc = 0; pc < case_len[c]; pc++)
        begin
            w   = prog[c][pc];
            a   = exp_regs[w[25:21]];
            b   = exp_regs[w[20:16]];
            imm = {{16{w[15]}}, w[15:0]};
            val = '0;
            dst = w[20:16];
            wr  = 1'b0;
            case (w[31:26])
                `MIPS_OP_RTYPE:
                begin
                    dst = w[15:11];
                    wr  = 1'b1;
                    case (w[5:0])
                        `MIPS_FN_ADD: val = a + b;
                        `MIPS_FN_SUB: val = a - b;
                        `MIPS_FN_AND: val = a & b;
                        `MIPS_FN_OR:  val = a | b;
                        `MIPS_FN_SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:      wr = 1'b0;
                    endcase
                end
                `MIPS_OP_ADDI:
                begin
                    val = a + imm;
                    wr  = 1'b1;
                end
                `MIPS_OP_LW:
                begin
                    val = model_mem[((a + imm) >> 2) % `MIPS_DMEM_WORDS];
                    wr  = 1'b1;
                end
                `MIPS_OP_SW:
                    model_mem[((a + imm) >> 2) % `MIPS_DMEM_WORDS] = b;
                default:
                    wr = 1'b0;
            endcase
            if (wr && dst != 5'd0)
                exp_regs[dst] = val;
        end
    endtask

    task wait_edges(input int n);
        int count;
        count = 0;
        while (count < n && count < MAX_WAIT)
        begin
            @(posedge SYS_clk);
            count++;
        end
        if (count < n)
        begin
            $display("timeout: program did not finish within %0d cycles", MAX_WAIT);
            timeouts++;
        end
    endtask

    task run_case(input int c);
        int a;
        int i;
        @(posedge SYS_clk);
        SYS_reset <= 1'b1;
        run       <= 1'b0;
        imem_we   <= 1'b0;
        repeat (5) @(posedge SYS_clk);
        SYS_reset <= 1'b0;
        for (a = 0; a < `MIPS_IMEM_WORDS; a++)
        begin
            imem_we   <= 1'b1;
            imem_addr <= a[5:0];
            imem_data <= (a < case_len[c]) ? prog[c][a] : 32'h0; // nop padding
            @(posedge SYS_clk);
        end
        imem_we <= 1'b0;
        run     <= 1'b1;
        wait_edges(case_len[c] + 6);
        run <= 1'b0;  // no second pass after PC wrap
        for (i = 0; i < 32; i++)
        begin
            reg_addr <= i[4:0];
            @(negedge SYS_clk);
            checks++;
            if (reg_data !== exp_regs[i])
            begin
                $display("CHECK FAILED %s r%0d expected %h actual %h",
                         case_name[c], i, exp_regs[i], reg_data);
                errors++;
            end
            @(posedge SYS_clk);
        end
    endtask

    initial
    begin
        SYS_clk   = 1'b0;
        SYS_reset = 1'b1;
        run       = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        reg_addr  = '0;
        rng_state = 32'hdfd7_29c2;
        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        build_cases();
        for (int c = 0; c < NCASES; c++)
        begin
            model_case(c);
            run_case(c);
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: hdl/mips_core.sv
////////////////////////////////////////
// five-stage core, no branches or jumps
// hold run low while loading imem
////////////////////////////////////////
`timescale 1ns/1ns
`include "mips_defs.svh"

module mips_core
(
    input  logic                               SYS_clk,
    input  logic                               SYS_reset,
    input  logic                               run,
    input  logic                               imem_we,
    input  logic [$clog2(`MIPS_IMEM_WORDS)-1:0] imem_addr,
    input  logic [`MIPS_XLEN-1:0]              imem_data,
    input  logic [$clog2(`MIPS_NREGS)-1:0]     reg_addr,
    output logic [`MIPS_XLEN-1:0]              reg_data
);

    logic [`MIPS_XLEN-1:0]          id_instr;
    logic [`MIPS_XLEN-1:0]          rs_data;
    logic [`MIPS_XLEN-1:0]          rt_data;
    logic                           wb_reg_write;
    logic [$clog2(`MIPS_NREGS)-1:0] wb_write_reg;
    logic [`MIPS_XLEN-1:0]          wb_write_data;

    ex_ctrl_if ex_ctrl ();
    ex_mem_if  ex_mem ();

    fetch_unit fetch_i
    (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .run       (run),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .id_instr  (id_instr)
    );

    pipeline_control control_i
    (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .id_instr     (id_instr),
        .ctrl         (ex_ctrl.ctrl),
        .ex_mem       (ex_mem.snoop),
        .wb_reg_write (wb_reg_write),
        .wb_write_reg (wb_write_reg)
    );

    register_file regfile_i
    (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .rs_addr       (id_instr[25:21]),
        .rt_addr       (id_instr[20:16]),
        .reg_addr      (reg_addr),
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .reg_data      (reg_data),
        .wb_reg_write  (wb_reg_write),
        .wb_write_reg  (wb_write_reg),
        .wb_write_data (wb_write_data)
    );

    execute_unit execute_i
    (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .id_instr      (id_instr),
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .ctrl          (ex_ctrl.exec),
        .ex_mem        (ex_mem.src),
        .wb_write_data (wb_write_data)
    );

    memory_unit memory_i
    (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .ex_mem        (ex_mem.dst),
        .wb_reg_write  (wb_reg_write),
        .wb_write_reg  (wb_write_reg),
        .wb_write_data (wb_write_data)
    );

endmodule

// File: hdl/memory_unit.sv
////////////////////////////////////////
// word-addressed dmem, low 2 address bits dropped
// addresses wrap at the dmem depth
////////////////////////////////////////
`timescale 1ns/1ns
`include "mips_defs.svh"

module memory_unit
(
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    ex_mem_if.dst               ex_mem,
    output logic                wb_reg_write,
    output mips_pkg::reg_addr_t wb_write_reg,
    output mips_pkg::word_t     wb_write_data
);

    localparam int DMEM_AW = $clog2(`MIPS_DMEM_WORDS);

    mips_pkg::word_t    dmem [0:`MIPS_DMEM_WORDS-1];
    logic [DMEM_AW-1:0] dmem_idx;
    mips_pkg::word_t    load_q;       // MEM/WB load data
    mips_pkg::word_t    alu_q;        // MEM/WB alu result
    logic               mem_to_reg_q;

    assign dmem_idx = ex_mem.alu_result[DMEM_AW+1:2]; // byte address / 4

    always_ff @(posedge SYS_clk)
    begin
        if (ex_mem.mem_write)
            dmem[dmem_idx] <= ex_mem.store_data;
    end

    // MEM/WB
    always_ff @(posedge SYS_clk)
    begin
        alu_q        <= ex_mem.alu_result;
        wb_write_reg <= ex_mem.write_reg;
        if (ex_mem.mem_read)
            load_q <= dmem[dmem_idx]; // only loads update it
        if (SYS_reset)
        begin
            wb_reg_write <= 1'b0;
            mem_to_reg_q <= 1'b0;
        end
        else
        begin
            wb_reg_write <= ex_mem.reg_write;
            mem_to_reg_q <= ex_mem.mem_to_reg;
        end
    end

    assign wb_write_data = mem_to_reg_q ? load_q : alu_q;

endmodule

// File: hdl/execute_unit.sv
////////////////////////////////////////
// ID/EX operands, forwarding, ALU, EX/MEM
////////////////////////////////////////
`timescale 1ns/1ns
`include "mips_defs.svh"

module execute_unit
(
    input  logic            SYS_clk,
    input  logic            SYS_reset,
    input  mips_pkg::word_t id_instr,
    input  mips_pkg::word_t rs_data,
    input  mips_pkg::word_t rt_data,
    ex_ctrl_if.exec         ctrl,
    ex_mem_if.src           ex_mem,
    input  mips_pkg::word_t wb_write_data
);

    mips_pkg::word_t op_a_q;    // ID/EX rs value
    mips_pkg::word_t op_b_q;    // ID/EX rt value
    mips_pkg::word_t imm_q;
    mips_pkg::word_t op_a;
    mips_pkg::word_t rt_fwd;    // also the store data
    mips_pkg::word_t op_b;
    mips_pkg::word_t alu_result;

    always_ff @(posedge SYS_clk)
    begin
        op_a_q <= rs_data;
        op_b_q <= rt_data;
        imm_q  <= {{(`MIPS_XLEN-16){id_instr[15]}}, id_instr[15:0]};
    end

    function automatic mips_pkg::word_t fwd_mux
    (
        input mips_pkg::fwd_sel_e sel,
        input mips_pkg::word_t    reg_val,
        input mips_pkg::word_t    mem_val,
        input mips_pkg::word_t    wb_val
    );
        case (sel)
            mips_pkg::fwd_from_mem: return mem_val;
            mips_pkg::fwd_from_wb:  return wb_val;
            default:                return reg_val;
        endcase
    endfunction

    assign op_a   = fwd_mux(ctrl.fwd_a, op_a_q, ex_mem.alu_result, wb_write_data);
    assign rt_fwd = fwd_mux(ctrl.fwd_b, op_b_q, ex_mem.alu_result, wb_write_data);
    assign op_b   = ctrl.alu_src_imm ? imm_q : rt_fwd;

    always_comb
    begin
        case (ctrl.alu_op)
            mips_pkg::alu_sub: alu_result = op_a - op_b;
            mips_pkg::alu_and: alu_result = op_a & op_b;
            mips_pkg::alu_or:  alu_result = op_a | op_b;
            mips_pkg::alu_slt: alu_result = mips_pkg::word_t'($signed(op_a) < $signed(op_b));
            default:           alu_result = op_a + op_b; // add, address calc
        endcase
    end

    // EX/MEM
    always_ff @(posedge SYS_clk)
    begin
        ex_mem.alu_result <= alu_result;
        ex_mem.store_data <= rt_fwd;
        ex_mem.write_reg  <= ctrl.write_reg;
        if (SYS_reset)
        begin
            ex_mem.reg_write  <= 1'b0;
            ex_mem.mem_read   <= 1'b0;
            ex_mem.mem_write  <= 1'b0;
            ex_mem.mem_to_reg <= 1'b0;
        end
        else
        begin
            ex_mem.reg_write  <= ctrl.reg_write;
            ex_mem.mem_read   <= ctrl.mem_read;
            ex_mem.mem_write  <= ctrl.mem_write;
            ex_mem.mem_to_reg <= ctrl.mem_to_reg;
        end
    end

endmodule

// File: hdl/register_file.sv
////////////////////////////////////////
// r0 reads zero, writes to it are dropped
// decode ports see a same-cycle write
////////////////////////////////////////
`timescale 1ns/1ns
`include "mips_defs.svh"

module register_file
(
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    input  mips_pkg::reg_addr_t reg_addr,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    output mips_pkg::word_t     reg_data,
    input  logic                wb_reg_write,
    input  mips_pkg::reg_addr_t wb_write_reg,
    input  mips_pkg::word_t     wb_write_data
);

    mips_pkg::word_t regs [0:`MIPS_NREGS-1];
    logic            wb_valid;

    assign wb_valid = wb_reg_write && (wb_write_reg != '0);

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < `MIPS_NREGS; i++)
                regs[i] <= '0;
        end
        else if (wb_valid)
            regs[wb_write_reg] <= wb_write_data;
    end

    assign rs_data  = (wb_valid && wb_write_reg == rs_addr) ? wb_write_data : regs[rs_addr];
    assign rt_data  = (wb_valid && wb_write_reg == rt_addr) ? wb_write_data : regs[rt_addr];
    assign reg_data = regs[reg_addr]; // observe port updates at the write edge

endmodule

// File: hdl/fetch_unit.sv
////////////////////////////////////////
// PC wraps at the imem depth
// load the program while run is low
////////////////////////////////////////
`timescale 1ns/1ns
`include "mips_defs.svh"

module fetch_unit
(
    input  logic                 SYS_clk,
    input  logic                 SYS_reset,
    input  logic                 run,
    input  logic                 imem_we,
    input  mips_pkg::imem_addr_t imem_addr,
    input  mips_pkg::word_t      imem_data,
    output mips_pkg::word_t      id_instr
);

    mips_pkg::word_t      imem [0:`MIPS_IMEM_WORDS-1];
    mips_pkg::imem_addr_t pc;   // word index

    always_ff @(posedge SYS_clk)
    begin
        if (imem_we)
            imem[imem_addr] <= imem_data; // load port
    end

    // PC and IF/ID
    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || !run)
        begin
            pc       <= '0;
            id_instr <= '0;  // nop
        end
        else
        begin
            pc       <= pc + 1'b1;
            id_instr <= imem[pc];
        end
    end

endmodule

// File: hdl/pipeline_control.sv
////////////////////////////////////////
// decode, ID/EX control and forwarding
// no load-use stall, lw result needs a gap
////////////////////////////////////////
`timescale 1ns/1ns
`include "mips_defs.svh"

module pipeline_control
(
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::word_t     id_instr,
    ex_ctrl_if.ctrl             ctrl,
    ex_mem_if.snoop             ex_mem,
    input  logic                wb_reg_write,
    input  mips_pkg::reg_addr_t wb_write_reg
);

    logic [5:0]          opcode;
    logic [5:0]          funct;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    mips_pkg::alu_op_e   dec_alu_op;
    logic                dec_alu_src_imm;
    logic                dec_mem_read;
    logic                dec_mem_write;
    logic                dec_reg_write;
    logic                dec_mem_to_reg;
    logic                dec_dst_rd;      // R-type writes rd
    mips_pkg::reg_addr_t ex_rs;           // ID/EX source indices
    mips_pkg::reg_addr_t ex_rt;

    assign opcode = id_instr[31:26];
    assign rs     = id_instr[25:21];
    assign rt     = id_instr[20:16];
    assign rd     = id_instr[15:11];
    assign funct  = id_instr[5:0];

    always_comb
    begin
        dec_alu_op      = mips_pkg::alu_add;
        dec_alu_src_imm = 1'b0;
        dec_mem_read    = 1'b0;
        dec_mem_write   = 1'b0;
        dec_reg_write   = 1'b0;
        dec_mem_to_reg  = 1'b0;
        dec_dst_rd      = 1'b0;
        case (opcode)
            `MIPS_OP_RTYPE:
            begin
                dec_dst_rd    = 1'b1;
                dec_reg_write = 1'b1;
                case (funct)
                    `MIPS_FN_ADD: dec_alu_op = mips_pkg::alu_add;
                    `MIPS_FN_SUB: dec_alu_op = mips_pkg::alu_sub;
                    `MIPS_FN_AND: dec_alu_op = mips_pkg::alu_and;
                    `MIPS_FN_OR:  dec_alu_op = mips_pkg::alu_or;
                    `MIPS_FN_SLT: dec_alu_op = mips_pkg::alu_slt;
                    default:      dec_reg_write = 1'b0; // all-zero word lands here
                endcase
            end
            `MIPS_OP_ADDI:
            begin
                dec_alu_src_imm = 1'b1;
                dec_reg_write   = 1'b1;
            end
            `MIPS_OP_LW:
            begin
                dec_alu_src_imm = 1'b1;
                dec_mem_read    = 1'b1;
                dec_reg_write   = 1'b1;
                dec_mem_to_reg  = 1'b1;
            end
            `MIPS_OP_SW:
            begin
                dec_alu_src_imm = 1'b1;
                dec_mem_write   = 1'b1;
            end
            default:
                dec_reg_write = 1'b0; // unknown opcode retires as nop
        endcase
    end

    // ID/EX control register
    always_ff @(posedge SYS_clk)
    begin
        ctrl.alu_op      <= dec_alu_op;
        ctrl.alu_src_imm <= dec_alu_src_imm;
        ctrl.write_reg   <= dec_dst_rd ? rd : rt;
        ex_rs            <= rs;
        ex_rt            <= rt;
        if (SYS_reset)
        begin
            ctrl.mem_read   <= 1'b0;
            ctrl.mem_write  <= 1'b0;
            ctrl.reg_write  <= 1'b0;
            ctrl.mem_to_reg <= 1'b0;
        end
        else
        begin
            ctrl.mem_read   <= dec_mem_read;
            ctrl.mem_write  <= dec_mem_write;
            ctrl.reg_write  <= dec_reg_write;
            ctrl.mem_to_reg <= dec_mem_to_reg;
        end
    end

    // newest producer wins, r0 never forwarded
    function automatic mips_pkg::fwd_sel_e fwd_select
    (
        input mips_pkg::reg_addr_t src,
        input logic                mem_we,
        input mips_pkg::reg_addr_t mem_reg,
        input logic                wb_we,
        input mips_pkg::reg_addr_t wb_reg
    );
        if (mem_we && mem_reg != '0 && mem_reg == src)
            return mips_pkg::fwd_from_mem;
        else if (wb_we && wb_reg != '0 && wb_reg == src)
            return mips_pkg::fwd_from_wb;
        else
            return mips_pkg::fwd_none;
    endfunction

    always_comb
    begin
        ctrl.fwd_a = fwd_select(ex_rs, ex_mem.reg_write, ex_mem.write_reg,
                                wb_reg_write, wb_write_reg);
        ctrl.fwd_b = fwd_select(ex_rt, ex_mem.reg_write, ex_mem.write_reg,
                                wb_reg_write, wb_write_reg);
    end

endmodule

// File: hdl/ex_mem_if.sv
////////////////////////////////////////
// EX/MEM pipeline register contents
////////////////////////////////////////
`timescale 1ns/1ns

interface ex_mem_if;

    mips_pkg::word_t     alu_result;  // also the byte address for lw/sw
    mips_pkg::word_t     store_data;
    mips_pkg::reg_addr_t write_reg;
    logic                reg_write;
    logic                mem_read;
    logic                mem_write;
    logic                mem_to_reg;

    modport src
    (
        output alu_result, store_data, write_reg, reg_write, mem_read, mem_write, mem_to_reg
    );

    modport dst
    (
        input alu_result, store_data, write_reg, reg_write, mem_read, mem_write, mem_to_reg
    );

    // forwarding compare only
    modport snoop
    (
        input write_reg, reg_write
    );

endinterface

// File: hdl/ex_ctrl_if.sv
////////////////////////////////////////
// execute-stage control bundle
// fwd selects are combinational
////////////////////////////////////////
`timescale 1ns/1ns

interface ex_ctrl_if;

    mips_pkg::alu_op_e   alu_op;
    logic                alu_src_imm; // b operand is the immediate
    mips_pkg::fwd_sel_e  fwd_a;       // rs source
    mips_pkg::fwd_sel_e  fwd_b;       // rt source
    logic                mem_read;
    logic                mem_write;
    logic                reg_write;
    logic                mem_to_reg;
    mips_pkg::reg_addr_t write_reg;   // rd or rt

    modport ctrl
    (
        output alu_op, alu_src_imm, fwd_a, fwd_b,
        output mem_read, mem_write, reg_write, mem_to_reg, write_reg
    );

    modport exec
    (
        input alu_op, alu_src_imm, fwd_a, fwd_b,
        input mem_read, mem_write, reg_write, mem_to_reg, write_reg
    );

endinterface

// File: hdl/mips_pkg.sv
////////////////////////////////////////
// shared types of the core
// widths come from mips_defs.svh
////////////////////////////////////////
`include "mips_defs.svh"

package mips_pkg;

    typedef logic [`MIPS_XLEN-1:0]               word_t;      // datum or instruction
    typedef logic [$clog2(`MIPS_NREGS)-1:0]      reg_addr_t;
    typedef logic [$clog2(`MIPS_IMEM_WORDS)-1:0] imem_addr_t; // word index, not bytes

    typedef enum logic [2:0]
    {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4   // signed compare
    } alu_op_e;

    // operand source in the execute stage
    typedef enum logic [1:0]
    {
        fwd_none     = 2'd0, // value from ID/EX
        fwd_from_mem = 2'd1, // EX/MEM alu result
        fwd_from_wb  = 2'd2  // writeback data
    } fwd_sel_e;

endpackage

// File: hdl/mips_defs.svh
////////////////////////////////////////
// core sizes and the supported encodings
// anything not listed here decodes as nop
////////////////////////////////////////
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

`define MIPS_XLEN       32
`define MIPS_NREGS      32
`define MIPS_IMEM_WORDS 64
`define MIPS_DMEM_WORDS 64

`define MIPS_OP_RTYPE   6'h00
`define MIPS_OP_ADDI    6'h08
`define MIPS_OP_LW      6'h23
`define MIPS_OP_SW      6'h2b

`define MIPS_FN_ADD     6'h20
`define MIPS_FN_SUB     6'h22
`define MIPS_FN_AND     6'h24
`define MIPS_FN_OR      6'h25
`define MIPS_FN_SLT     6'h2a

`endif
